// File: logic/channel_lane.sv
// channel lane
// 4-bit result for one colour, from its own byte or the shared grey value

`include "filter_consts.svh"

module channel_lane import filter_pkg::*; #(
    // 0 red, 1 green, 2 blue
    parameter int CHANNEL = 0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  filter_mode_t            mode_i,
    input  logic [3*`FLT_PIX_W-1:0] rgb_i,
    input  logic [`FLT_PIX_W-1:0]   gray_i,
    output logic [`FLT_OUT_W-1:0]   chan_o
);

    localparam filter_mode_t TINT_MODE = (CHANNEL == 0) ? MODE_RED_TINT :
                                         (CHANNEL == 1) ? MODE_GREEN_TINT :
                                                          MODE_BLUE_TINT;

    logic [`FLT_PIX_W-1:0] pixel;
    logic [`FLT_PIX_W:0]   bright_sum;
    logic [`FLT_PIX_W-1:0] bright;
    logic [`FLT_PIX_W-1:0] dark;
    logic [`FLT_OUT_W-1:0] chan_next;

    assign pixel = rgb_i[CHANNEL*`FLT_PIX_W +: `FLT_PIX_W];

    // saturating step up and down
    assign bright_sum = {1'b0, pixel} + (`FLT_PIX_W+1)'(`FLT_BRIGHT_STEP);
    assign bright = (bright_sum > (`FLT_PIX_W+1)'(`FLT_PIX_MAX)) ?
                    `FLT_PIX_W'(`FLT_PIX_MAX) : bright_sum[`FLT_PIX_W-1:0];
    assign dark   = (pixel < `FLT_PIX_W'(`FLT_BRIGHT_STEP)) ?
                    '0 : pixel - `FLT_PIX_W'(`FLT_BRIGHT_STEP);

    always_comb begin
        case (mode_i)
            MODE_PASS:     chan_next = pixel[`FLT_PIX_W-1 -: `FLT_OUT_W];
            MODE_BRIGHTEN: chan_next = bright[`FLT_PIX_W-1 -: `FLT_OUT_W];
            MODE_DARKEN:   chan_next = dark[`FLT_PIX_W-1 -: `FLT_OUT_W];
            MODE_RED_TINT, MODE_GREEN_TINT, MODE_BLUE_TINT: begin
                // full scale on the tinted channel only
                chan_next = (mode_i == TINT_MODE) ? '1 : pixel[`FLT_PIX_W-1 -: `FLT_OUT_W];
            end
            MODE_GRAY, MODE_BOX_BLUR, MODE_GAUSS, MODE_LAPLACE, MODE_SHARPEN: begin
                chan_next = gray_i[`FLT_PIX_W-1 -: `FLT_OUT_W];
            end
            default:       chan_next = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            chan_o <= '0;
        end else begin
            chan_o <= chan_next;
        end
    end

endmodule

// File: logic/filter_consts.svh
// image filter constants
// widths, brightness step, clamp ceiling and pipeline depth

`ifndef FILTER_CONSTS_SVH
`define FILTER_CONSTS_SVH

// grey or channel sample
`define FLT_PIX_W 8

// output colour channel
`define FLT_OUT_W 4

// horizontal and vertical counters
`define FLT_POS_W 11

// added by brighten, taken away by darken
`define FLT_BRIGHT_STEP 6

// clamp ceiling for 8-bit results
`define FLT_PIX_MAX 255

// input to output, in clock cycles
`define FLT_LATENCY 4

`endif

// File: logic/filter_pkg.sv
// image filter types
// filter mode codes shared by the pipeline stages

package filter_pkg;

    // codes 7, 9, 11, 12 and 14 are unused and give black
    typedef enum logic [3:0] {
        MODE_PASS       = 4'd0,
        MODE_BRIGHTEN   = 4'd1,
        MODE_DARKEN     = 4'd2,
        MODE_GRAY       = 4'd3,
        MODE_RED_TINT   = 4'd4,
        MODE_BLUE_TINT  = 4'd5,
        MODE_GREEN_TINT = 4'd6,
        // window modes
        MODE_BOX_BLUR   = 4'd8,
        MODE_LAPLACE    = 4'd10,
        MODE_SHARPEN    = 4'd13,
        MODE_GAUSS      = 4'd15
    } filter_mode_t;

endpackage

// File: logic/gray_reduce.sv
// grey reduction
// luma or 3x3 kernel result for the current mode, clamped to 8 bits

`include "filter_consts.svh"

module gray_reduce import filter_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  filter_mode_t            mode_i,
    input  logic [3*`FLT_PIX_W-1:0] rgb_i,
    input  logic [`FLT_PIX_W-1:0]   gray_c_i,
    input  logic [`FLT_PIX_W-1:0]   gray_n_i,
    input  logic [`FLT_PIX_W-1:0]   gray_s_i,
    input  logic [`FLT_PIX_W-1:0]   gray_e_i,
    input  logic [`FLT_PIX_W-1:0]   gray_w_i,
    input  logic [`FLT_PIX_W-1:0]   gray_ne_i,
    input  logic [`FLT_PIX_W-1:0]   gray_nw_i,
    input  logic [`FLT_PIX_W-1:0]   gray_se_i,
    input  logic [`FLT_PIX_W-1:0]   gray_sw_i,
    output logic [`FLT_PIX_W-1:0]   gray_o
);

    localparam int SUM_W = `FLT_PIX_W + 4;
    localparam int ACC_W = SUM_W + 1;

    logic [`FLT_PIX_W-1:0]   red;
    logic [`FLT_PIX_W-1:0]   green;
    logic [`FLT_PIX_W-1:0]   blue;
    logic [`FLT_PIX_W+1:0]   luma;
    logic [SUM_W-1:0]        sum_orth;
    logic [SUM_W-1:0]        sum_diag;
    logic [SUM_W-1:0]        sum_all;
    logic [SUM_W-1:0]        sum_gauss;
    logic [SUM_W-1:0]        box_avg;
    logic signed [ACC_W-1:0] value;
    logic [`FLT_PIX_W-1:0]   gray_next;

    assign red   = rgb_i[`FLT_PIX_W-1:0];
    assign green = rgb_i[2*`FLT_PIX_W-1:`FLT_PIX_W];
    assign blue  = rgb_i[3*`FLT_PIX_W-1:2*`FLT_PIX_W];

    // shift-sum approximation of 0.28r + 0.56g + 0.09b
    assign luma = (red >> 2) + (red >> 5) + (green >> 1) + (green >> 4)
                + (blue >> 4) + (blue >> 5);

    assign sum_orth  = gray_n_i + gray_s_i + gray_e_i + gray_w_i;
    assign sum_diag  = gray_ne_i + gray_nw_i + gray_se_i + gray_sw_i;
    assign sum_all   = sum_orth + sum_diag + gray_c_i;
    // 1-2-1 / 2-4-2 / 1-2-1
    assign sum_gauss = {gray_c_i, 2'b00} + {sum_orth[SUM_W-2:0], 1'b0} + sum_diag;
    assign box_avg   = sum_all / SUM_W'(9);

    always_comb begin
        case (mode_i)
            MODE_GRAY:     value = $signed({3'b000, luma});
            MODE_BOX_BLUR: value = $signed({1'b0, box_avg});
            MODE_GAUSS:    value = $signed({5'b00000, sum_gauss[SUM_W-1:4]});
            MODE_LAPLACE:  value = $signed({2'b00, gray_c_i, 3'b000})
                                 - $signed({1'b0, sum_orth + sum_diag});
            MODE_SHARPEN:  value = $signed({3'b000, gray_c_i, 2'b00})
                                 + $signed({5'b00000, gray_c_i})
                                 - $signed({1'b0, sum_orth});
            default:       value = '0;
        endcase
    end

    // clamp to 0..255
    always_comb begin
        if (value < 0) begin
            gray_next = '0;
        end else if (value > ACC_W'(`FLT_PIX_MAX)) begin
            gray_next = `FLT_PIX_W'(`FLT_PIX_MAX);
        end else begin
            gray_next = value[`FLT_PIX_W-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            gray_o <= '0;
        end else begin
            gray_o <= gray_next;
        end
    end

endmodule

// File: logic/image_filter_top.sv
// image filter top
// four-cycle pixel filter: capture, grey reduction, three lanes, output

`include "filter_consts.svh"

module image_filter_top import filter_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [3*`FLT_PIX_W-1:0] rgb_i,
    input  logic [`FLT_PIX_W-1:0]   gray_c_i,
    input  logic [`FLT_PIX_W-1:0]   gray_n_i,
    input  logic [`FLT_PIX_W-1:0]   gray_s_i,
    input  logic [`FLT_PIX_W-1:0]   gray_e_i,
    input  logic [`FLT_PIX_W-1:0]   gray_w_i,
    input  logic [`FLT_PIX_W-1:0]   gray_ne_i,
    input  logic [`FLT_PIX_W-1:0]   gray_nw_i,
    input  logic [`FLT_PIX_W-1:0]   gray_se_i,
    input  logic [`FLT_PIX_W-1:0]   gray_sw_i,
    input  filter_mode_t            mode_i,
    input  logic                    blank_n_i,
    input  logic [`FLT_POS_W-1:0]   hcount_i,
    input  logic [`FLT_POS_W-1:0]   vcount_i,
    output logic [`FLT_OUT_W-1:0]   red_o,
    output logic [`FLT_OUT_W-1:0]   green_o,
    output logic [`FLT_OUT_W-1:0]   blue_o,
    output logic [`FLT_POS_W-1:0]   hcount_o,
    output logic [`FLT_POS_W-1:0]   vcount_o
);

    logic [3*`FLT_PIX_W-1:0] rgb_s1;
    logic [`FLT_PIX_W-1:0]   gray_c_s1;
    logic [`FLT_PIX_W-1:0]   gray_n_s1;
    logic [`FLT_PIX_W-1:0]   gray_s_s1;
    logic [`FLT_PIX_W-1:0]   gray_e_s1;
    logic [`FLT_PIX_W-1:0]   gray_w_s1;
    logic [`FLT_PIX_W-1:0]   gray_ne_s1;
    logic [`FLT_PIX_W-1:0]   gray_nw_s1;
    logic [`FLT_PIX_W-1:0]   gray_se_s1;
    logic [`FLT_PIX_W-1:0]   gray_sw_s1;
    filter_mode_t            mode_s1;
    logic [3*`FLT_PIX_W-1:0] rgb_s2;
    filter_mode_t            mode_s2;
    logic                    blank_n_s2;
    logic [`FLT_POS_W-1:0]   hcount_s2;
    logic [`FLT_POS_W-1:0]   vcount_s2;
    logic [`FLT_PIX_W-1:0]   gray_s2;
    logic [`FLT_OUT_W-1:0]   lane_chan [3];

    pixel_capture u_pixel_capture (
        .clock        (clock),
        .reset        (reset),
        .rgb_i        (rgb_i),
        .gray_c_i     (gray_c_i),
        .gray_n_i     (gray_n_i),
        .gray_s_i     (gray_s_i),
        .gray_e_i     (gray_e_i),
        .gray_w_i     (gray_w_i),
        .gray_ne_i    (gray_ne_i),
        .gray_nw_i    (gray_nw_i),
        .gray_se_i    (gray_se_i),
        .gray_sw_i    (gray_sw_i),
        .mode_i       (mode_i),
        .blank_n_i    (blank_n_i),
        .hcount_i     (hcount_i),
        .vcount_i     (vcount_i),
        .rgb_s1_o     (rgb_s1),
        .gray_c_s1_o  (gray_c_s1),
        .gray_n_s1_o  (gray_n_s1),
        .gray_s_s1_o  (gray_s_s1),
        .gray_e_s1_o  (gray_e_s1),
        .gray_w_s1_o  (gray_w_s1),
        .gray_ne_s1_o (gray_ne_s1),
        .gray_nw_s1_o (gray_nw_s1),
        .gray_se_s1_o (gray_se_s1),
        .gray_sw_s1_o (gray_sw_s1),
        .mode_s1_o    (mode_s1),
        .rgb_s2_o     (rgb_s2),
        .mode_s2_o    (mode_s2),
        .blank_n_s2_o (blank_n_s2),
        .hcount_s2_o  (hcount_s2),
        .vcount_s2_o  (vcount_s2)
    );

    gray_reduce u_gray_reduce (
        .clock     (clock),
        .reset     (reset),
        .mode_i    (mode_s1),
        .rgb_i     (rgb_s1),
        .gray_c_i  (gray_c_s1),
        .gray_n_i  (gray_n_s1),
        .gray_s_i  (gray_s_s1),
        .gray_e_i  (gray_e_s1),
        .gray_w_i  (gray_w_s1),
        .gray_ne_i (gray_ne_s1),
        .gray_nw_i (gray_nw_s1),
        .gray_se_i (gray_se_s1),
        .gray_sw_i (gray_sw_s1),
        .gray_o    (gray_s2)
    );

    // one lane per colour, red first
    for (genvar ch = 0; ch < 3; ch++) begin : g_lane
        channel_lane #(
            .CHANNEL (ch)
        ) u_channel_lane (
            .clock  (clock),
            .reset  (reset),
            .mode_i (mode_s2),
            .rgb_i  (rgb_s2),
            .gray_i (gray_s2),
            .chan_o (lane_chan[ch])
        );
    end

    video_output u_video_output (
        .clock     (clock),
        .reset     (reset),
        .red_i     (lane_chan[0]),
        .green_i   (lane_chan[1]),
        .blue_i    (lane_chan[2]),
        .blank_n_i (blank_n_s2),
        .hcount_i  (hcount_s2),
        .vcount_i  (vcount_s2),
        .red_o     (red_o),
        .green_o   (green_o),
        .blue_o    (blue_o),
        .hcount_o  (hcount_o),
        .vcount_o  (vcount_o)
    );

endmodule

// File: logic/pixel_capture.sv
// pixel capture
// input register plus a second stage that keeps channels, mode and timing
// in step with the grey path

`include "filter_consts.svh"

module pixel_capture import filter_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [3*`FLT_PIX_W-1:0]   rgb_i,
    input  logic [`FLT_PIX_W-1:0]     gray_c_i,
    input  logic [`FLT_PIX_W-1:0]     gray_n_i,
    input  logic [`FLT_PIX_W-1:0]     gray_s_i,
    input  logic [`FLT_PIX_W-1:0]     gray_e_i,
    input  logic [`FLT_PIX_W-1:0]     gray_w_i,
    input  logic [`FLT_PIX_W-1:0]     gray_ne_i,
    input  logic [`FLT_PIX_W-1:0]     gray_nw_i,
    input  logic [`FLT_PIX_W-1:0]     gray_se_i,
    input  logic [`FLT_PIX_W-1:0]     gray_sw_i,
    input  filter_mode_t              mode_i,
    input  logic                      blank_n_i,
    input  logic [`FLT_POS_W-1:0]     hcount_i,
    input  logic [`FLT_POS_W-1:0]     vcount_i,
    output logic [3*`FLT_PIX_W-1:0]   rgb_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_c_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_n_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_s_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_e_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_w_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_ne_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_nw_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_se_s1_o,
    output logic [`FLT_PIX_W-1:0]     gray_sw_s1_o,
    output filter_mode_t              mode_s1_o,
    output logic [3*`FLT_PIX_W-1:0]   rgb_s2_o,
    output filter_mode_t              mode_s2_o,
    output logic                      blank_n_s2_o,
    output logic [`FLT_POS_W-1:0]     hcount_s2_o,
    output logic [`FLT_POS_W-1:0]     vcount_s2_o
);

    logic                  blank_n_s1;
    logic [`FLT_POS_W-1:0] hcount_s1;
    logic [`FLT_POS_W-1:0] vcount_s1;

    // first stage, everything as sampled
    always_ff @(posedge clock) begin
        if (reset) begin
            rgb_s1_o     <= '0;
            gray_c_s1_o  <= '0;
            gray_n_s1_o  <= '0;
            gray_s_s1_o  <= '0;
            gray_e_s1_o  <= '0;
            gray_w_s1_o  <= '0;
            gray_ne_s1_o <= '0;
            gray_nw_s1_o <= '0;
            gray_se_s1_o <= '0;
            gray_sw_s1_o <= '0;
            mode_s1_o    <= MODE_PASS;
            blank_n_s1   <= 1'b0;
            hcount_s1    <= '0;
            vcount_s1    <= '0;
        end else begin
            rgb_s1_o     <= rgb_i;
            gray_c_s1_o  <= gray_c_i;
            gray_n_s1_o  <= gray_n_i;
            gray_s_s1_o  <= gray_s_i;
            gray_e_s1_o  <= gray_e_i;
            gray_w_s1_o  <= gray_w_i;
            gray_ne_s1_o <= gray_ne_i;
            gray_nw_s1_o <= gray_nw_i;
            gray_se_s1_o <= gray_se_i;
            gray_sw_s1_o <= gray_sw_i;
            mode_s1_o    <= mode_i;
            blank_n_s1   <= blank_n_i;
            hcount_s1    <= hcount_i;
            vcount_s1    <= vcount_i;
        end
    end

    // second stage, window not needed past the grey reduction
    always_ff @(posedge clock) begin
        if (reset) begin
            rgb_s2_o     <= '0;
            mode_s2_o    <= MODE_PASS;
            blank_n_s2_o <= 1'b0;
            hcount_s2_o  <= '0;
            vcount_s2_o  <= '0;
        end else begin
            rgb_s2_o     <= rgb_s1_o;
            mode_s2_o    <= mode_s1_o;
            blank_n_s2_o <= blank_n_s1;
            hcount_s2_o  <= hcount_s1;
            vcount_s2_o  <= vcount_s1;
        end
    end

endmodule

// File: logic/video_output.sv
// video output stage
// lines blanking and position up with the lane results, blanks to black

`include "filter_consts.svh"

module video_output (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`FLT_OUT_W-1:0] red_i,
    input  logic [`FLT_OUT_W-1:0] green_i,
    input  logic [`FLT_OUT_W-1:0] blue_i,
    input  logic                  blank_n_i,
    input  logic [`FLT_POS_W-1:0] hcount_i,
    input  logic [`FLT_POS_W-1:0] vcount_i,
    output logic [`FLT_OUT_W-1:0] red_o,
    output logic [`FLT_OUT_W-1:0] green_o,
    output logic [`FLT_OUT_W-1:0] blue_o,
    output logic [`FLT_POS_W-1:0] hcount_o,
    output logic [`FLT_POS_W-1:0] vcount_o
);

    logic                  blank_n_d;
    logic [`FLT_POS_W-1:0] hcount_d;
    logic [`FLT_POS_W-1:0] vcount_d;

    // matches the lane register
    always_ff @(posedge clock) begin
        if (reset) begin
            blank_n_d <= 1'b0;
            hcount_d  <= '0;
            vcount_d  <= '0;
        end else begin
            blank_n_d <= blank_n_i;
            hcount_d  <= hcount_i;
            vcount_d  <= vcount_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            red_o    <= '0;
            green_o  <= '0;
            blue_o   <= '0;
            hcount_o <= '0;
            vcount_o <= '0;
        end else begin
            red_o    <= blank_n_d ? red_i : '0;
            green_o  <= blank_n_d ? green_i : '0;
            blue_o   <= blank_n_d ? blue_i : '0;
            // counters run through even while blanked
            hcount_o <= hcount_d;
            vcount_o <= vcount_d;
        end
    end

endmodule

// File: verification/filter_model.svh
// reference model of the image filter
// expected {blue, green, red} nibbles for one mode, pixel and 3x3 window

`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

`include "filter_consts.svh"

// window bytes from the bottom: c, n, s, e, w, ne, nw, se, sw
function automatic logic [11:0] expected_colour(input filter_mode_t mode,
                                                input logic [23:0]  rgb,
                                                input logic [71:0]  win);
    int          s [9];
    int          r;
    int          g;
    int          b;
    int          orth;
    int          diag;
    int          grey;
    int          px;
    int          level;
    int          i;
    logic [11:0] colour;

    for (i = 0; i < 9; i++) begin
        s[i] = win[i*8 +: 8];
    end
    r    = rgb[7:0];
    g    = rgb[15:8];
    b    = rgb[23:16];
    orth = s[1] + s[2] + s[3] + s[4];
    diag = s[5] + s[6] + s[7] + s[8];

    case (mode)
        MODE_GRAY:     grey = r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32;
        MODE_BOX_BLUR: grey = (s[0] + orth + diag) / 9;
        MODE_GAUSS:    grey = (4 * s[0] + 2 * orth + diag) / 16;
        MODE_LAPLACE:  grey = 8 * s[0] - orth - diag;
        MODE_SHARPEN:  grey = 5 * s[0] - orth;
        default:       grey = 0;
    endcase
    if (grey < 0) begin
        grey = 0;
    end else if (grey > `FLT_PIX_MAX) begin
        grey = `FLT_PIX_MAX;
    end

    colour = '0;
    for (i = 0; i < 3; i++) begin
        px = rgb[i*8 +: 8];
        case (mode)
            MODE_PASS:       level = px;
            MODE_BRIGHTEN:   level = (px + `FLT_BRIGHT_STEP > `FLT_PIX_MAX) ?
                                     `FLT_PIX_MAX : px + `FLT_BRIGHT_STEP;
            MODE_DARKEN:     level = (px < `FLT_BRIGHT_STEP) ? 0 : px - `FLT_BRIGHT_STEP;
            // full scale on the tinted colour
            MODE_RED_TINT:   level = (i == 0) ? 255 : px;
            MODE_GREEN_TINT: level = (i == 1) ? 255 : px;
            MODE_BLUE_TINT:  level = (i == 2) ? 255 : px;
            MODE_GRAY, MODE_BOX_BLUR, MODE_GAUSS, MODE_LAPLACE, MODE_SHARPEN: begin
                level = grey;
            end
            default:         level = 0;
        endcase
        colour[i*4 +: 4] = 4'(level / 16);
    end
    return colour;
endfunction

`endif

// File: verification/image_filter_tb.sv
// image filter testbench
// random and directed pixels through all modes, checked against the model

`include "filter_consts.svh"

module image_filter_tb import filter_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    `include "filter_model.svh"

    localparam int RESET_CYCLES    = 16;
    localparam int IDLE_CYCLES     = `FLT_LATENCY + 4;
    localparam int PER_MODE        = 200;
    localparam int PER_DROPPED     = 40;
    localparam int DIRECTED        = 8;
    localparam int MIXED_COUNT     = 300;
    localparam int STIM_CYCLES     = IDLE_CYCLES + 11 * PER_MODE + DIRECTED
                                   + 5 * PER_DROPPED + 2 * MIXED_COUNT;
    localparam int TIMEOUT_CYCLES  = 2 * STIM_CYCLES + RESET_CYCLES;

    typedef struct packed {
        logic [31:0] due;
        logic [3:0]  mode;
        logic [11:0] colour;
        logic        blank_n;
        logic [10:0] hcount;
        logic [10:0] vcount;
    } expect_t;

    logic                  clock;
    logic                  reset;
    logic [23:0]           rgb_i;
    logic [7:0]            gray_c_i;
    logic [7:0]            gray_n_i;
    logic [7:0]            gray_s_i;
    logic [7:0]            gray_e_i;
    logic [7:0]            gray_w_i;
    logic [7:0]            gray_ne_i;
    logic [7:0]            gray_nw_i;
    logic [7:0]            gray_se_i;
    logic [7:0]            gray_sw_i;
    filter_mode_t          mode_i;
    logic                  blank_n_i;
    logic [`FLT_POS_W-1:0] hcount_i;
    logic [`FLT_POS_W-1:0] vcount_i;
    logic [`FLT_OUT_W-1:0] red_o;
    logic [`FLT_OUT_W-1:0] green_o;
    logic [`FLT_OUT_W-1:0] blue_o;
    logic [`FLT_POS_W-1:0] hcount_o;
    logic [`FLT_POS_W-1:0] vcount_o;

    logic [31:0] rng_state;
    int          edge_count;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    expect_t     exp_q [$];
    expect_t     head;

    image_filter_top u_image_filter_top (
        .clock     (clock),
        .reset     (reset),
        .rgb_i     (rgb_i),
        .gray_c_i  (gray_c_i),
        .gray_n_i  (gray_n_i),
        .gray_s_i  (gray_s_i),
        .gray_e_i  (gray_e_i),
        .gray_w_i  (gray_w_i),
        .gray_ne_i (gray_ne_i),
        .gray_nw_i (gray_nw_i),
        .gray_se_i (gray_se_i),
        .gray_sw_i (gray_sw_i),
        .mode_i    (mode_i),
        .blank_n_i (blank_n_i),
        .hcount_i  (hcount_i),
        .vcount_i  (vcount_i),
        .red_o     (red_o),
        .green_o   (green_o),
        .blue_o    (blue_o),
        .hcount_o  (hcount_o),
        .vcount_o  (vcount_o)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        edge_count = 0;
    end

    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // near_limits keeps the byte within 7 of 0 or 255
    function logic [7:0] random_byte(input logic near_limits);
        logic [31:0] r;
        logic [7:0]  b;
        r = next_random();
        if (!near_limits) begin
            b = r[7:0];
        end else if (r[8]) begin
            b = {5'b11111, r[2:0]};
        end else begin
            b = {5'b00000, r[2:0]};
        end
        return b;
    endfunction

    function logic [71:0] random_window(input logic near_limits);
        logic [71:0] w;
        int          i;
        for (i = 0; i < 9; i++) begin
            w[i*8 +: 8] = random_byte(near_limits);
        end
        return w;
    endfunction

    function automatic logic [71:0] ring_window(input logic [7:0] centre,
                                                input logic [7:0] ring);
        return {{8{ring}}, centre};
    endfunction

    task automatic send_sample(input filter_mode_t mode, input logic [23:0] rgb,
                               input logic [71:0] win, input logic blank_n);
        expect_t     item;
        logic [31:0] r;
        r = next_random();
        @(negedge clock);
        rgb_i     = rgb;
        gray_c_i  = win[7:0];
        gray_n_i  = win[15:8];
        gray_s_i  = win[23:16];
        gray_e_i  = win[31:24];
        gray_w_i  = win[39:32];
        gray_ne_i = win[47:40];
        gray_nw_i = win[55:48];
        gray_se_i = win[63:56];
        gray_sw_i = win[71:64];
        mode_i    = mode;
        blank_n_i = blank_n;
        hcount_i  = r[10:0];
        vcount_i  = r[26:16];
        item.due     = edge_count + `FLT_LATENCY;
        item.mode    = mode;
        item.colour  = expected_colour(mode, rgb, win);
        item.blank_n = blank_n;
        item.hcount  = r[10:0];
        item.vcount  = r[26:16];
        exp_q.push_back(item);
    endtask

    task automatic check_output(input expect_t item);
        logic [11:0] want;
        logic [11:0] got;
        want = item.blank_n ? item.colour : 12'h000;
        got  = {blue_o, green_o, red_o};
        check_count++;
        assert (got == want) else begin
            error_count++;
            $display("** Error at %0t: mode %0d blank_n %0b colour expected %h, got %h",
                     $time, item.mode, item.blank_n, want, got);
        end
        check_count++;
        assert (hcount_o == item.hcount && vcount_o == item.vcount) else begin
            error_count++;
            $display("** Error at %0t: counters expected %0d/%0d, got %0d/%0d",
                     $time, item.hcount, item.vcount, hcount_o, vcount_o);
        end
    endtask

    // outputs are stable between rising edges
    always @(negedge clock) begin
        if (exp_q.size() > 0 && exp_q[0].due == edge_count) begin
            head = exp_q.pop_front();
            check_output(head);
        end
    end

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    // first look is at reset release, before any rising edge runs the pipeline
    task automatic check_idle_outputs();
        int k;
        for (k = 0; k < IDLE_CYCLES; k++) begin
            check_count++;
            assert ({red_o, green_o, blue_o, hcount_o, vcount_o} == '0) else begin
                error_count++;
                $display("** Error at %0t: idle outputs expected 0, got %h %h %h %0d %0d",
                         $time, red_o, green_o, blue_o, hcount_o, vcount_o);
            end
            @(negedge clock);
        end
    endtask

    task automatic run_random_mode(input filter_mode_t mode, input int count);
        int          k;
        logic        edge_bias;
        logic [23:0] rgb;
        for (k = 0; k < count; k++) begin
            // every fourth pixel sits near the saturation limits
            edge_bias = (k % 4 == 3);
            rgb = {random_byte(edge_bias), random_byte(edge_bias), random_byte(edge_bias)};
            send_sample(mode, rgb, random_window(edge_bias), 1'b1);
        end
    endtask

    task automatic run_directed_windows();
        filter_mode_t kernels [2];
        int           m;
        kernels[0] = MODE_LAPLACE;
        kernels[1] = MODE_SHARPEN;
        for (m = 0; m < 2; m++) begin
            send_sample(kernels[m], 24'h808080, ring_window(8'd255, 8'd0), 1'b1);
            send_sample(kernels[m], 24'h808080, ring_window(8'd0, 8'd255), 1'b1);
            send_sample(kernels[m], 24'h808080, ring_window(8'd40, 8'd30), 1'b1);
            send_sample(kernels[m], 24'h808080, ring_window(8'd30, 8'd40), 1'b1);
        end
    endtask

    task automatic run_blanking();
        int          k;
        logic [31:0] r;
        for (k = 0; k < MIXED_COUNT; k++) begin
            r = next_random();
            send_sample(filter_mode_t'(r[3:0]), {random_byte(0), random_byte(0),
                        random_byte(0)}, random_window(0), r[4]);
        end
    endtask

    task automatic run_mode_switching();
        filter_mode_t valid_modes [11];
        int           k;
        int           idx;
        valid_modes = '{MODE_PASS, MODE_BRIGHTEN, MODE_DARKEN, MODE_GRAY, MODE_RED_TINT,
                        MODE_BLUE_TINT, MODE_GREEN_TINT, MODE_BOX_BLUR, MODE_LAPLACE,
                        MODE_SHARPEN, MODE_GAUSS};
        idx = 0;
        for (k = 0; k < MIXED_COUNT; k++) begin
            // never the same mode twice in a row
            idx = (idx + 1 + int'(next_random() % 10)) % 11;
            send_sample(valid_modes[idx], {random_byte(0), random_byte(0), random_byte(0)},
                        random_window(0), 1'b1);
        end
    endtask

    initial begin : watchdog
        while (edge_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main_sequence
        filter_mode_t point_modes [6];
        filter_mode_t grey_modes [5];
        int           dropped [5];
        int           m;

        point_modes = '{MODE_PASS, MODE_BRIGHTEN, MODE_DARKEN, MODE_RED_TINT,
                        MODE_GREEN_TINT, MODE_BLUE_TINT};
        grey_modes  = '{MODE_GRAY, MODE_BOX_BLUR, MODE_GAUSS, MODE_LAPLACE, MODE_SHARPEN};
        dropped     = '{7, 9, 11, 12, 14};
        rng_state   = 32'd92356;
        check_count = 0;
        error_count = 0;
        reset       = 1'b1;
        rgb_i       = '0;
        gray_c_i    = '0;
        gray_n_i    = '0;
        gray_s_i    = '0;
        gray_e_i    = '0;
        gray_w_i    = '0;
        gray_ne_i   = '0;
        gray_nw_i   = '0;
        gray_se_i   = '0;
        gray_sw_i   = '0;
        mode_i      = MODE_PASS;
        blank_n_i   = 1'b0;
        hcount_i    = '0;
        vcount_i    = '0;

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        start_test();
        check_idle_outputs();
        end_test("idle after reset");

        start_test();
        for (m = 0; m < 6; m++) begin
            run_random_mode(point_modes[m], PER_MODE);
        end
        end_test("point modes");

        start_test();
        for (m = 0; m < 5; m++) begin
            run_random_mode(grey_modes[m], PER_MODE);
        end
        run_directed_windows();
        end_test("grey and window modes");

        start_test();
        for (m = 0; m < 5; m++) begin
            run_random_mode(filter_mode_t'(dropped[m]), PER_DROPPED);
        end
        end_test("dropped codes");

        start_test();
        run_blanking();
        end_test("blanking");

        start_test();
        run_mode_switching();
        end_test("mode switching");

        $display("checks passed: %0d, failed: %0d", check_count - error_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
+incdir+verification
logic/filter_pkg.sv
logic/pixel_capture.sv
logic/gray_reduce.sv
logic/channel_lane.sv
logic/video_output.sv
logic/image_filter_top.sv
verification/image_filter_tb.sv
